// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = bb_top_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = CHECKS FAILED
PASS_MSG  = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: fail"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then echo "Result: run ended early"; exit 1; \
	else echo "Result: pass"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim.f ====
source/bb_cfg_pkg.sv
source/bb_regmap_pkg.sv
source/blink_timebase.sv
source/led_pattern.sv
source/drive_ctrl_regs.sv
source/status_readback.sv
source/bb_top.sv
verification/bb_top_asserts.sv
verification/bb_top_tb.sv

// ==== source/bb_cfg_pkg.sv ====
// Baseboard drive-bay core configuration
// Bus widths, drive limits and the vector types shared by every block

package bb_cfg_pkg;

	// Largest drive count the register map can address
	localparam int MAX_DRIVES = 16;

	typedef logic [7:0] byte_t;
	typedef logic [7:0] addr_t;
	typedef logic [3:0] page_t;
	typedef logic [3:0] ofs_t;
	typedef logic [2:0] phase_t;

	// One bit per drive slot
	typedef logic [MAX_DRIVES-1:0] drive_vec_t;

	// Ones for the populated slots, zeros above
	function automatic drive_vec_t drive_mask(input int num);
		drive_vec_t m;
		m = '0;
		for (int i = 0; i < MAX_DRIVES; i++)
		begin
			if (i < num)
				m[i] = 1'b1;
		end
		return m;
	endfunction

endpackage

// ==== source/bb_regmap_pkg.sv ====
// Baseboard drive-bay core register map
// Page codes, offsets, identity bytes, reset values and LED mode codes

package bb_regmap_pkg;

	//**********************************************************
	// Page codes, upper nibble of the host address
	//**********************************************************
	localparam bb_cfg_pkg::page_t PAGE_ID     = 4'h0;
	localparam bb_cfg_pkg::page_t PAGE_PRSNT  = 4'h1;
	localparam bb_cfg_pkg::page_t PAGE_PWR_EN = 4'h2;
	localparam bb_cfg_pkg::page_t PAGE_PWROK  = 4'h3;
	localparam bb_cfg_pkg::page_t PAGE_AMBER  = 4'h4;
	localparam bb_cfg_pkg::page_t PAGE_BLUE   = 4'h6;
	localparam bb_cfg_pkg::page_t PAGE_ALERT  = 4'h9;

	//**********************************************************
	// Offsets inside the bit-vector pages
	//**********************************************************
	// Drives 0 to 7
	localparam bb_cfg_pkg::ofs_t OFS_LOW        = 4'h0;
	// Drives 8 to 15
	localparam bb_cfg_pkg::ofs_t OFS_HIGH       = 4'h1;
	// Identify bytes, present page only
	localparam bb_cfg_pkg::ofs_t OFS_IDENT_LOW  = 4'h6;
	localparam bb_cfg_pkg::ofs_t OFS_IDENT_HIGH = 4'h7;

	// Identity bytes, page 0 offsets 0 to 3
	localparam bb_cfg_pkg::byte_t DEVICE_ID_MSB = 8'hB5;
	localparam bb_cfg_pkg::byte_t DEVICE_ID_LSB = 8'h1C;
	localparam bb_cfg_pkg::byte_t CPLD_MAJ_VER  = 8'h01;
	localparam bb_cfg_pkg::byte_t CPLD_MIN_VER  = 8'h03;

	// Drives come up powered
	localparam bb_cfg_pkg::drive_vec_t PWR_EN_RESET = '1;

	// Per-drive LED mode, codes 5 to 7 give a dark LED
	typedef enum logic [2:0] {
		LED_OFF       = 3'd0,
		LED_ON        = 3'd1,
		LED_BLINK_1HZ = 3'd2,
		LED_BLINK_2HZ = 3'd3,
		LED_BLINK_4HZ = 3'd4
	} led_mode_t;

endpackage

// ==== source/bb_top.sv ====
// Baseboard drive-bay control core
// Host register port, power enables, drive LEDs and heartbeat

`timescale 1ns/1ps

module bb_top #(
	parameter int NUM_DRIVES    = 12,
	parameter int TICKS_PER_SEC = 25_000_000
) (
	input  logic                   SYSCLK,
	input  logic                   RESET_N,
	// Host access port
	input  bb_cfg_pkg::addr_t      bus_addr,
	input  bb_cfg_pkg::byte_t      bus_wdata,
	input  logic                   bus_wr,
	input  logic                   bus_rd,
	output bb_cfg_pkg::byte_t      bus_rdata,
	// Drive bay pins
	input  bb_cfg_pkg::drive_vec_t drv_present,
	input  bb_cfg_pkg::drive_vec_t drv_ident,
	input  bb_cfg_pkg::drive_vec_t drv_pwrok,
	input  logic                   alert_l,
	output bb_cfg_pkg::drive_vec_t drv_pwr_en_l,
	output bb_cfg_pkg::drive_vec_t drv_pcie_clk_oe_l,
	output bb_cfg_pkg::drive_vec_t amber_led,
	output bb_cfg_pkg::drive_vec_t blue_led,
	output logic                   heart
);

	bb_cfg_pkg::drive_vec_t                       pwr_en;
	bb_regmap_pkg::led_mode_t [NUM_DRIVES-1:0]    amber_mode;
	bb_regmap_pkg::led_mode_t [NUM_DRIVES-1:0]    blue_mode;
	logic                                         blink_1hz;
	logic                                         blink_2hz;
	logic                                         blink_4hz;

	//**********************************************************
	// Host writes and power gating
	//**********************************************************
	drive_ctrl_regs #(.NUM_DRIVES(NUM_DRIVES)) drive_regs (
		.SYSCLK            (SYSCLK),
		.RESET_N           (RESET_N),
		.bus_addr          (bus_addr),
		.bus_wdata         (bus_wdata),
		.bus_wr            (bus_wr),
		.drv_present       (drv_present),
		.pwr_en            (pwr_en),
		.amber_mode        (amber_mode),
		.blue_mode         (blue_mode),
		.drv_pwr_en_l      (drv_pwr_en_l),
		.drv_pcie_clk_oe_l (drv_pcie_clk_oe_l)
	);

	// Host reads
	status_readback #(.NUM_DRIVES(NUM_DRIVES)) readback (
		.SYSCLK      (SYSCLK),
		.RESET_N     (RESET_N),
		.bus_addr    (bus_addr),
		.bus_rd      (bus_rd),
		.drv_present (drv_present),
		.drv_ident   (drv_ident),
		.drv_pwrok   (drv_pwrok),
		.alert_l     (alert_l),
		.pwr_en      (pwr_en),
		.amber_mode  (amber_mode),
		.blue_mode   (blue_mode),
		.bus_rdata   (bus_rdata)
	);

	//**********************************************************
	// Blink timebase and LED drivers
	//**********************************************************
	blink_timebase #(.TICKS_PER_SEC(TICKS_PER_SEC)) timebase (
		.SYSCLK    (SYSCLK),
		.RESET_N   (RESET_N),
		.blink_1hz (blink_1hz),
		.blink_2hz (blink_2hz),
		.blink_4hz (blink_4hz),
		.heart     (heart)
	);

	led_pattern #(.NUM_DRIVES(NUM_DRIVES)) amber_leds (
		.mode      (amber_mode),
		.blink_1hz (blink_1hz),
		.blink_2hz (blink_2hz),
		.blink_4hz (blink_4hz),
		.led       (amber_led)
	);

	led_pattern #(.NUM_DRIVES(NUM_DRIVES)) blue_leds (
		.mode      (blue_mode),
		.blink_1hz (blink_1hz),
		.blink_2hz (blink_2hz),
		.blink_4hz (blink_4hz),
		.led       (blue_led)
	);

endmodule

// ==== source/blink_timebase.sv ====
// Blink timebase
// Eighth-second phase counter giving the 4, 2 and 1 Hz blink phases,
// plus a heartbeat that toggles once per second

`timescale 1ns/1ps

module blink_timebase #(
	parameter int TICKS_PER_SEC = 25_000_000
) (
	input  logic SYSCLK,
	input  logic RESET_N,
	output logic blink_1hz,
	output logic blink_2hz,
	output logic blink_4hz,
	output logic heart
);

	// One phase step per eighth of a second
	localparam int TICKS_PER_PHASE = TICKS_PER_SEC / 8;
	localparam int CNT_W = (TICKS_PER_PHASE > 1) ? $clog2(TICKS_PER_PHASE) : 1;

	logic [CNT_W-1:0]   tick_cnt;
	logic               step;
	bb_cfg_pkg::phase_t phase;

	assign step = (tick_cnt == CNT_W'(TICKS_PER_PHASE - 1));

	//**********************************************************
	// Tick and phase counters
	//**********************************************************
	// First step lands on the TICKS_PER_PHASE-th edge after release
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			tick_cnt <= '0;
			phase    <= '0;
		end
		else if (step)
		begin
			tick_cnt <= '0;
			phase    <= phase + 3'd1;
		end
		else
		begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// Heartbeat flips on the 7 to 0 wrap
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
			heart <= 1'b0;
		else if (step && (phase == 3'd7))
			heart <= ~heart;
	end

	assign blink_4hz = phase[0];
	assign blink_2hz = phase[1];
	assign blink_1hz = phase[2];

endmodule

// ==== source/drive_ctrl_regs.sv ====
// Drive control registers
// Host writes to power enable and LED mode registers,
// presence-gated active-low power and PCIe clock enables

`timescale 1ns/1ps

module drive_ctrl_regs #(
	parameter int NUM_DRIVES = 12
) (
	input  logic                                      SYSCLK,
	input  logic                                      RESET_N,
	input  bb_cfg_pkg::addr_t                         bus_addr,
	input  bb_cfg_pkg::byte_t                         bus_wdata,
	input  logic                                      bus_wr,
	input  bb_cfg_pkg::drive_vec_t                    drv_present,
	output bb_cfg_pkg::drive_vec_t                    pwr_en,
	output bb_regmap_pkg::led_mode_t [NUM_DRIVES-1:0] amber_mode,
	output bb_regmap_pkg::led_mode_t [NUM_DRIVES-1:0] blue_mode,
	output bb_cfg_pkg::drive_vec_t                    drv_pwr_en_l,
	output bb_cfg_pkg::drive_vec_t                    drv_pcie_clk_oe_l
);

	// Slots above NUM_DRIVES never hold an enable
	localparam bb_cfg_pkg::drive_vec_t DRIVE_MASK = bb_cfg_pkg::drive_mask(NUM_DRIVES);

	bb_cfg_pkg::page_t      wr_page;
	bb_cfg_pkg::ofs_t       wr_ofs;
	logic                   pwr_wr;
	logic                   amber_wr;
	logic                   blue_wr;
	bb_cfg_pkg::drive_vec_t pwr_en_l;

	assign wr_page  = bus_addr[7:4];
	assign wr_ofs   = bus_addr[3:0];
	assign pwr_wr   = bus_wr && (wr_page == bb_regmap_pkg::PAGE_PWR_EN);
	assign amber_wr = bus_wr && (wr_page == bb_regmap_pkg::PAGE_AMBER);
	assign blue_wr  = bus_wr && (wr_page == bb_regmap_pkg::PAGE_BLUE);

	//**********************************************************
	// Power enable bytes, page 0x2
	//**********************************************************
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			pwr_en <= bb_regmap_pkg::PWR_EN_RESET & DRIVE_MASK;
		end
		else if (pwr_wr)
		begin
			case (wr_ofs)
				bb_regmap_pkg::OFS_LOW:
					pwr_en <= {pwr_en[8 +: 8], bus_wdata} & DRIVE_MASK;
				bb_regmap_pkg::OFS_HIGH:
					pwr_en <= {bus_wdata, pwr_en[0 +: 8]} & DRIVE_MASK;
				default:
					pwr_en <= pwr_en;
			endcase
		end
	end

	//**********************************************************
	// LED modes, one register per drive, offset selects the drive
	//**********************************************************
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			for (int i = 0; i < NUM_DRIVES; i++)
			begin
				amber_mode[i] <= bb_regmap_pkg::LED_OFF;
				blue_mode[i]  <= bb_regmap_pkg::LED_OFF;
			end
		end
		else
		begin
			for (int i = 0; i < NUM_DRIVES; i++)
			begin
				// Codes 5 to 7 are kept so they read back as written
				if (amber_wr && (wr_ofs == 4'(i)))
					amber_mode[i] <= bb_regmap_pkg::led_mode_t'(bus_wdata[2:0]);
				if (blue_wr && (wr_ofs == 4'(i)))
					blue_mode[i] <= bb_regmap_pkg::led_mode_t'(bus_wdata[2:0]);
			end
		end
	end

	// Power only reaches a drive that is seated
	assign pwr_en_l          = ~(pwr_en & drv_present);
	assign drv_pwr_en_l      = pwr_en_l;
	// Reference clock follows the power rail
	assign drv_pcie_clk_oe_l = pwr_en_l;

endmodule

// ==== source/led_pattern.sv ====
// LED pattern generator
// Turns each drive's mode register into an LED level from the
// shared blink phases

`timescale 1ns/1ps

module led_pattern #(
	parameter int NUM_DRIVES = 12
) (
	input  bb_regmap_pkg::led_mode_t [NUM_DRIVES-1:0] mode,
	input  logic                                      blink_1hz,
	input  logic                                      blink_2hz,
	input  logic                                      blink_4hz,
	output bb_cfg_pkg::drive_vec_t                    led
);

	always_comb
	begin
		// Slots above NUM_DRIVES stay dark
		led = '0;
		for (int i = 0; i < NUM_DRIVES; i++)
		begin
			case (mode[i])
				bb_regmap_pkg::LED_ON:
					led[i] = 1'b1;
				bb_regmap_pkg::LED_BLINK_1HZ:
					led[i] = blink_1hz;
				bb_regmap_pkg::LED_BLINK_2HZ:
					led[i] = blink_2hz;
				bb_regmap_pkg::LED_BLINK_4HZ:
					led[i] = blink_4hz;
				// Off and the spare codes 5 to 7
				default:
					led[i] = 1'b0;
			endcase
		end
	end

endmodule

// ==== source/status_readback.sv ====
// Status readback
// Selects the addressed register byte and holds it on the read bus
// until the next read strobe

`timescale 1ns/1ps

module status_readback #(
	parameter int NUM_DRIVES = 12
) (
	input  logic                                      SYSCLK,
	input  logic                                      RESET_N,
	input  bb_cfg_pkg::addr_t                         bus_addr,
	input  logic                                      bus_rd,
	input  bb_cfg_pkg::drive_vec_t                    drv_present,
	input  bb_cfg_pkg::drive_vec_t                    drv_ident,
	input  bb_cfg_pkg::drive_vec_t                    drv_pwrok,
	input  logic                                      alert_l,
	input  bb_cfg_pkg::drive_vec_t                    pwr_en,
	input  bb_regmap_pkg::led_mode_t [NUM_DRIVES-1:0] amber_mode,
	input  bb_regmap_pkg::led_mode_t [NUM_DRIVES-1:0] blue_mode,
	output bb_cfg_pkg::byte_t                         bus_rdata
);

	localparam bb_cfg_pkg::drive_vec_t DRIVE_MASK = bb_cfg_pkg::drive_mask(NUM_DRIVES);

	bb_cfg_pkg::page_t      rd_page;
	bb_cfg_pkg::ofs_t       rd_ofs;
	bb_cfg_pkg::drive_vec_t present_m;
	bb_cfg_pkg::drive_vec_t ident_m;
	bb_cfg_pkg::drive_vec_t pwrok_m;
	bb_cfg_pkg::byte_t      rd_sel;

	assign rd_page = bus_addr[7:4];
	assign rd_ofs  = bus_addr[3:0];

	// Empty slots read as zero
	assign present_m = drv_present & DRIVE_MASK;
	assign ident_m   = drv_ident & DRIVE_MASK;
	assign pwrok_m   = drv_pwrok & DRIVE_MASK;

	// Byte select for the two-byte vector pages
	function automatic bb_cfg_pkg::byte_t vec_byte(
		input bb_cfg_pkg::drive_vec_t vec,
		input bb_cfg_pkg::ofs_t       ofs
	);
		case (ofs)
			bb_regmap_pkg::OFS_LOW:  return vec[0 +: 8];
			bb_regmap_pkg::OFS_HIGH: return vec[8 +: 8];
			default:                 return '0;
		endcase
	endfunction

	//**********************************************************
	// Read mux
	//**********************************************************
	always_comb
	begin
		rd_sel = '0;
		case (rd_page)
			bb_regmap_pkg::PAGE_ID:
			begin
				case (rd_ofs)
					4'h0:    rd_sel = bb_regmap_pkg::DEVICE_ID_MSB;
					4'h1:    rd_sel = bb_regmap_pkg::DEVICE_ID_LSB;
					4'h2:    rd_sel = bb_regmap_pkg::CPLD_MAJ_VER;
					4'h3:    rd_sel = bb_regmap_pkg::CPLD_MIN_VER;
					default: rd_sel = '0;
				endcase
			end
			bb_regmap_pkg::PAGE_PRSNT:
			begin
				if (rd_ofs == bb_regmap_pkg::OFS_IDENT_LOW)
					rd_sel = ident_m[0 +: 8];
				else if (rd_ofs == bb_regmap_pkg::OFS_IDENT_HIGH)
					rd_sel = ident_m[8 +: 8];
				else
					rd_sel = vec_byte(present_m, rd_ofs);
			end
			bb_regmap_pkg::PAGE_PWR_EN: rd_sel = vec_byte(pwr_en, rd_ofs);
			bb_regmap_pkg::PAGE_PWROK:  rd_sel = vec_byte(pwrok_m, rd_ofs);
			bb_regmap_pkg::PAGE_AMBER, bb_regmap_pkg::PAGE_BLUE:
			begin
				for (int i = 0; i < NUM_DRIVES; i++)
				begin
					if (rd_ofs == 4'(i))
						rd_sel = (rd_page == bb_regmap_pkg::PAGE_AMBER) ?
							{5'b0, amber_mode[i]} : {5'b0, blue_mode[i]};
				end
			end
			bb_regmap_pkg::PAGE_ALERT:
			begin
				// Raw pin level in bit 0
				if (rd_ofs == 4'h0)
					rd_sel = {7'b0, alert_l};
			end
			default: rd_sel = '0;
		endcase
	end

	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
			bus_rdata <= '0;
		else if (bus_rd)
			bus_rdata <= rd_sel;
	end

endmodule

// ==== verification/bb_top_asserts.sv ====
// Bound checks on the drive-bay core top level
// Clock enables track power enables, absent drives stay unpowered,
// read data holds between read strobes

`timescale 1ns/1ps

module bb_top_asserts (
	input logic                   SYSCLK,
	input logic                   RESET_N,
	input logic                   bus_rd,
	input bb_cfg_pkg::byte_t      bus_rdata,
	input bb_cfg_pkg::drive_vec_t drv_present,
	input bb_cfg_pkg::drive_vec_t drv_pwr_en_l,
	input bb_cfg_pkg::drive_vec_t drv_pcie_clk_oe_l
);

	// Assertion failures seen so far
	int fail_count = 0;

	clk_oe_follows_pwr: assert property (
		@(posedge SYSCLK) drv_pcie_clk_oe_l == drv_pwr_en_l
	) else
	begin
		$error("PCIe clock enable differs from the power enable");
		fail_count++;
	end

	// No power to an empty slot
	absent_unpowered: assert property (
		@(posedge SYSCLK) (~drv_present & ~drv_pwr_en_l) == '0
	) else
	begin
		$error("Power enabled on a drive that is not present");
		fail_count++;
	end

	rdata_holds: assert property (
		@(posedge SYSCLK) disable iff (!RESET_N) !bus_rd |=> $stable(bus_rdata)
	) else
	begin
		$error("Read data changed without a read strobe");
		fail_count++;
	end

endmodule

bind bb_top bb_top_asserts checks (.*);

// ==== verification/bb_top_tb.sv ====
// Testbench for the drive-bay control core
// Plays the vector file against bb_top and checks reads, power
// outputs, LEDs and heartbeat against a model of the blink timebase

`timescale 1ns/1ps

module bb_top_tb;

	localparam int NUM_DRIVES      = 12;
	localparam int TICKS_PER_SEC   = 80;
	localparam int TICKS_PER_PHASE = TICKS_PER_SEC / 8;

	logic                   SYSCLK;
	logic                   RESET_N;
	bb_cfg_pkg::addr_t      bus_addr;
	bb_cfg_pkg::byte_t      bus_wdata;
	logic                   bus_wr;
	logic                   bus_rd;
	bb_cfg_pkg::byte_t      bus_rdata;
	bb_cfg_pkg::drive_vec_t drv_present;
	bb_cfg_pkg::drive_vec_t drv_ident;
	bb_cfg_pkg::drive_vec_t drv_pwrok;
	logic                   alert_l;
	bb_cfg_pkg::drive_vec_t drv_pwr_en_l;
	bb_cfg_pkg::drive_vec_t drv_pcie_clk_oe_l;
	bb_cfg_pkg::drive_vec_t amber_led;
	bb_cfg_pkg::drive_vec_t blue_led;
	logic                   heart;

	// Parsed vector file, one entry per operation
	string       op_q[$];
	string       name_q[$];
	logic [15:0] a_q[$];
	logic [15:0] b_q[$];
	logic [15:0] c_q[$];
	logic [15:0] d_q[$];

	// Mode registers as the host wrote them
	logic [2:0] amber_model [bb_cfg_pkg::MAX_DRIVES];
	logic [2:0] blue_model  [bb_cfg_pkg::MAX_DRIVES];

	string cur_test;
	int    run_edges;
	int    cycle_limit;
	int    num_tests;
	int    num_checks;
	int    num_errors;
	int    test_checks;
	int    test_errors;
	logic  load_ok;

	bb_top #(
		.NUM_DRIVES    (NUM_DRIVES),
		.TICKS_PER_SEC (TICKS_PER_SEC)
	) uut (
		.SYSCLK            (SYSCLK),
		.RESET_N           (RESET_N),
		.bus_addr          (bus_addr),
		.bus_wdata         (bus_wdata),
		.bus_wr            (bus_wr),
		.bus_rd            (bus_rd),
		.bus_rdata         (bus_rdata),
		.drv_present       (drv_present),
		.drv_ident         (drv_ident),
		.drv_pwrok         (drv_pwrok),
		.alert_l           (alert_l),
		.drv_pwr_en_l      (drv_pwr_en_l),
		.drv_pcie_clk_oe_l (drv_pcie_clk_oe_l),
		.amber_led         (amber_led),
		.blue_led          (blue_led),
		.heart             (heart)
	);

	initial
	begin
		SYSCLK = 1'b0;
		forever #10 SYSCLK = ~SYSCLK;
	end

	// Edges seen since reset release, drives the timebase model
	always @(posedge SYSCLK)
	begin
		if (RESET_N)
			run_edges <= run_edges + 1;
	end

	//************************************************************
	// Model and check helpers
	//************************************************************
	function automatic logic led_level(input logic [2:0] mode, input logic [2:0] phase);
		case (mode)
			3'd1:    return 1'b1;
			3'd2:    return phase[2];
			3'd3:    return phase[1];
			3'd4:    return phase[0];
			default: return 1'b0;
		endcase
	endfunction

	task automatic check(input string what, input logic [15:0] expected,
		input logic [15:0] actual);
		num_checks  += 1;
		test_checks += 1;
		if (actual !== expected)
		begin
			num_errors  += 1;
			test_errors += 1;
			$display("FAILED %s %s: expected %h, actual %h", cur_test, what, expected, actual);
		end
	endtask

	task automatic step_cycle();
		@(posedge SYSCLK);
		#2;
	endtask

	task automatic model_write(input logic [7:0] addr, input logic [7:0] data);
		int ofs;
		ofs = int'(addr[3:0]);
		// Offsets past the last drive are dropped
		if (ofs < NUM_DRIVES)
		begin
			if (addr[7:4] == bb_regmap_pkg::PAGE_AMBER)
				amber_model[ofs] = data[2:0];
			else if (addr[7:4] == bb_regmap_pkg::PAGE_BLUE)
				blue_model[ofs] = data[2:0];
		end
	endtask

	task automatic check_leds();
		bb_cfg_pkg::drive_vec_t amber_exp;
		bb_cfg_pkg::drive_vec_t blue_exp;
		logic [2:0]             phase;
		logic                   heart_exp;
		phase     = 3'((run_edges / TICKS_PER_PHASE) % 8);
		heart_exp = 1'((run_edges / TICKS_PER_SEC) % 2);
		amber_exp = '0;
		blue_exp  = '0;
		for (int k = 0; k < NUM_DRIVES; k++)
		begin
			amber_exp[k] = led_level(amber_model[k], phase);
			blue_exp[k]  = led_level(blue_model[k], phase);
		end
		check("amber_led", amber_exp, amber_led);
		check("blue_led", blue_exp, blue_led);
		check("heart", {15'b0, heart_exp}, {15'b0, heart});
	endtask

	task automatic report_test();
		if (cur_test != "")
		begin
			num_tests += 1;
			if (test_errors == 0)
				$display("Test %s: ok, %0d checks", cur_test, test_checks);
			else
				$display("Test %s: %0d mismatches in %0d checks", cur_test, test_errors,
					test_checks);
		end
	endtask

	//************************************************************
	// Vector file reader and player
	//************************************************************
	task automatic load_vectors(output logic ok);
		int          fd;
		int          n;
		string       line;
		string       op;
		string       name;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] c;
		logic [15:0] d;
		ok = 1'b0;
		fd = $fopen("verification/bb_top_vectors.txt", "r");
		if (fd != 0)
		begin
			ok = 1'b1;
			while (!$feof(fd))
			begin
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#")
				begin
					n = $sscanf(line, "%s", op);
					if (n == 1)
					begin
						name = "";
						a = '0;
						b = '0;
						c = '0;
						d = '0;
						if (op == "T")
							n = $sscanf(line, "%s %s", op, name);
						else
							n = $sscanf(line, "%s %h %h %h %h", op, a, b, c, d);
						op_q.push_back(op);
						name_q.push_back(name);
						a_q.push_back(a);
						b_q.push_back(b);
						c_q.push_back(c);
						d_q.push_back(d);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_op(input int i);
		if (op_q[i] == "T")
		begin
			report_test();
			cur_test    = name_q[i];
			test_checks = 0;
			test_errors = 0;
		end
		else if (op_q[i] == "P")
		begin
			drv_present = a_q[i];
			drv_ident   = b_q[i];
			drv_pwrok   = c_q[i];
			alert_l     = d_q[i][0];
			step_cycle();
		end
		else if (op_q[i] == "W")
		begin
			bus_addr  = a_q[i][7:0];
			bus_wdata = b_q[i][7:0];
			bus_wr    = 1'b1;
			step_cycle();
			bus_wr = 1'b0;
			model_write(a_q[i][7:0], b_q[i][7:0]);
		end
		else if (op_q[i] == "R")
		begin
			bus_addr = a_q[i][7:0];
			bus_rd   = 1'b1;
			step_cycle();
			bus_rd = 1'b0;
			check($sformatf("read %h", a_q[i][7:0]), b_q[i], {8'h00, bus_rdata});
		end
		else if (op_q[i] == "E")
		begin
			check("drv_pwr_en_l", a_q[i], drv_pwr_en_l);
			check("drv_pcie_clk_oe_l", a_q[i], drv_pcie_clk_oe_l);
		end
		else if (op_q[i] == "L")
		begin
			repeat (int'(b_q[i]))
			begin
				repeat (int'(a_q[i]))
					step_cycle();
				check_leds();
			end
		end
		else
		begin
			num_errors += 1;
			$display("Vector entry %0d has an unknown operation %s", i, op_q[i]);
		end
	endtask

	// Watchdog on the whole run
	initial
	begin
		int cycles;
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit)
		begin
			@(posedge SYSCLK);
			cycles += 1;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		RESET_N     = 1'b0;
		bus_addr    = '0;
		bus_wdata   = '0;
		bus_wr      = 1'b0;
		bus_rd      = 1'b0;
		drv_present = '0;
		drv_ident   = '0;
		drv_pwrok   = '0;
		alert_l     = 1'b1;
		run_edges   = 0;
		cycle_limit = 0;
		num_tests   = 0;
		num_checks  = 0;
		num_errors  = 0;
		test_checks = 0;
		test_errors = 0;
		cur_test    = "";
		for (int k = 0; k < bb_cfg_pkg::MAX_DRIVES; k++)
		begin
			amber_model[k] = 3'd0;
			blue_model[k]  = 3'd0;
		end
		load_vectors(load_ok);
		if (!load_ok)
		begin
			$display("Cannot open the vector file verification/bb_top_vectors.txt");
			$display("CHECKS FAILED");
		end
		else
		begin
			cycle_limit = 40 * op_q.size() + 4 * TICKS_PER_SEC;
			repeat (16) @(posedge SYSCLK);
			#2;
			RESET_N = 1'b1;
			for (int i = 0; i < op_q.size(); i++)
				run_op(i);
			report_test();
			if (uut.checks.fail_count != 0)
			begin
				num_errors += uut.checks.fail_count;
				$display("Bound assertions failed %0d times", uut.checks.fail_count);
			end
			$display("Tests: %0d, checks: %0d, errors: %0d", num_tests, num_checks,
				num_errors);
			if (num_errors == 0)
				$display("ALL CHECKS PASSED");
			else
				$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== verification/bb_top_vectors.txt ====
# Hex fields. T name | P present ident pwrok alert_l | W addr data | R addr expect
# E pwr_en_l expect | L cycles count, LEDs and heart from the timebase model
T reset_state
L 0 1
R 20 FF
R 21 0F
T identity
R 00 B5
R 01 1C
R 02 01
R 03 03
R 04 00
R B0 00
R 4C 00
T pin_readback
P F35A 1234 FFF0 1
R 10 5A
R 11 03
R 16 34
R 17 02
R 30 F0
R 31 0F
R 90 01
T power_enables
E FCA5
W 20 0F
E FCF5
W 21 FE
E FDF5
R 20 0F
R 21 0E
P 0FFF 0000 0FFF 0
E F1F0
R 90 00
T led_static
W 40 01
L 0 1
R 40 01
W 6B 09
L 0 1
R 6B 01
W 40 FD
L 0 1
R 40 05
W 6C 01
R 6C 00
W 6B 00
L 0 1
T led_blink
W 41 02
W 42 03
W 43 04
W 65 02
W 66 03
W 67 04
L 7 23
T heartbeat
L 13 25
